//--- filelist.f
+incdir+include
hdl/trace_syntax_pkg.sv
hdl/trace_record_pkg.sv
hdl/char_classifier.sv
hdl/record_parser.sv
hdl/field_accumulator.sv
hdl/record_checker.sv
hdl/cpu_trace_checker.sv
sim/tb_cpu_trace_checker.sv

//--- sim/cpu_trace_stimulus.txt
// columns: freq (decimal), expected format (0 none, 1 reg, 2 mem), expected code (hex),
// then the record text from the first caret to the end of the line.
16 1 0 ^16@00003000:$31<=0000abcd#
16 1 8 ^24@00003004:$32<=12345678#
8 1 0 ^8@00004ffc: $7 <= 0000ffff#
16 2 0 ^32@00003008:*00000100<=deadbeef#
16 2 4 ^32@00003008:*00000102<=00000000#
16 2 4 ^40@0000300c:*00003000 <= 00000001#
16 1 2 ^48@00005000:$1<=00000000#
16 2 6 ^48@00003002:*00002ffe<=00000000#
16 1 2 ^0@00002ffc:$0<=00000000#
2 1 0 ^9999@00003000:$1<=00000000#
4 1 1 ^7@00003000:$1<=00000000#
4 1 0 ^6@00003000:$1<=00000000#
8192 1 1 ^4095@00003000:$1<=00000000#
8192 2 0 ^4096@00003000:*00000000<=00000000#
100 1 1 ^4096@00003000:$1<=00000000#
100 1 0 ^0@00003000:$1<=00000000#
1000 1 9 ^8@00003000:$99<=00000000#
16 0 0 ^16@0000300:$1<=00000000#
16 0 0 ^12345@00003000:$1<=00000000#
16 0 0 ^16@00003000$1<=00000000#
16 0 0 ^16@00003000:$1<=00000000x#
16 0 0 ^16@00003000:$12345<=00000000#
16 1 0 ^9999@00005001:$99^16@00003000:$5<=00000000#
4 2 4 ^12@0000300^8@00003004:*00003ffc<=00000000#

//--- sim/tb_cpu_trace_checker.sv
`timescale 1ns/1ps

module tb_cpu_trace_checker
        import trace_syntax_pkg::*;
        import trace_record_pkg::*;
();

        localparam int REPORT_TIMEOUT = 20;
        localparam string STIMULUS_PATH = "sim/cpu_trace_stimulus.txt";
        localparam char_t IDLE_CHAR = 8'h78; // 'x' is also the first filler.

        logic clk;
        logic reset;
        char_t char;
        freq_t freq;
        format_e format_type;
        error_code_t error_code;

        int error_count;
        int check_count;
        int record_count;

        cpu_trace_checker dut_i (
                .clk(clk),
                .reset(reset),
                .char(char),
                .freq(freq),
                .format_type(format_type),
                .error_code(error_code)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        task automatic compare_value(input string test_name, input string what,
                                     input logic [31:0] expected, input logic [31:0] actual);
                check_count++;
                if (expected !== actual) begin
                        error_count++;
                        $display("** Error: %s %s expected %0h actual %0h",
                                 test_name, what, expected, actual);
                end
        endtask

        // returns just after the falling edge, where outputs are stable.
        task automatic drive_char(input char_t c);
                @(negedge clk);
                char = c;
        endtask

        task automatic drive_filler();
                int unsigned count;
                count = $urandom % 6;
                repeat (count) begin
                        drive_char(char_t'(IDLE_CHAR + ($urandom % 3))); // x, y or z.
                end
        endtask

        task automatic expect_report(input string test_name, input int exp_format,
                                     input int exp_code);
                int cycles;
                cycles = 0;
                drive_char(IDLE_CHAR); // hash was taken at the last rising edge.
                while (format_type == FMT_NONE && cycles < REPORT_TIMEOUT) begin
                        drive_char(IDLE_CHAR);
                        cycles++;
                end
                if (format_type == FMT_NONE) begin
                        error_count++;
                        $display("%s: no report within %0d cycles after the hash",
                                 test_name, REPORT_TIMEOUT);
                end else begin
                        compare_value(test_name, "format_type", exp_format, format_type);
                        compare_value(test_name, "error_code", exp_code, error_code);
                        drive_char(IDLE_CHAR);
                        compare_value(test_name, "format_type one cycle later", FMT_NONE,
                                      format_type);
                        compare_value(test_name, "error_code one cycle later", 0, error_code);
                end
        endtask

        task automatic expect_silence(input string test_name);
                int cycles;
                logic seen;
                seen = 1'b0;
                for (cycles = 0; cycles < REPORT_TIMEOUT && !seen; cycles++) begin
                        drive_char(IDLE_CHAR);
                        seen = (format_type !== FMT_NONE);
                end
                compare_value(test_name, "format_type", FMT_NONE, format_type);
        endtask

        function automatic bit is_data_line(input string line);
                if (line.len() == 0) begin
                        return 1'b0;
                end
                return (line.getc(0) >= "0") && (line.getc(0) <= "9");
        endfunction

        task automatic run_line(input string line, input int line_no);
                int fields_read;
                int line_freq;
                int exp_format;
                int exp_code;
                int start;
                int stop;
                string test_name;
                fields_read = $sscanf(line, "%d %d %h", line_freq, exp_format, exp_code);
                test_name = $sformatf("line %0d", line_no);
                start = 0;
                while (start < line.len() && line.getc(start) != "^") begin
                        start++;
                end
                stop = line.len();
                while (stop > start && (line.getc(stop - 1) == "\n" ||
                                        line.getc(stop - 1) == "\r")) begin
                        stop--;
                end
                if (fields_read != 3 || start >= stop) begin
                        error_count++;
                        $display("%s: stimulus line has no readable record", test_name);
                end else begin
                        drive_filler();
                        freq = freq_t'(line_freq); // steady from caret to hash.
                        for (int i = start; i < stop; i++) begin
                                drive_char(char_t'(line.getc(i)));
                        end
                        record_count++;
                        if (exp_format == 0) begin
                                expect_silence(test_name);
                        end else begin
                                expect_report(test_name, exp_format, exp_code);
                        end
                end
        endtask

        initial begin
                int fd;
                int got;
                int line_no;
                string line;
                error_count = 0;
                check_count = 0;
                record_count = 0;
                void'($urandom(5));
                reset = 1'b1;
                char = IDLE_CHAR;
                freq = 16'd16;
                repeat (8) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                compare_value("reset", "format_type", FMT_NONE, format_type);
                compare_value("reset", "error_code", 0, error_code);

                fd = $fopen(STIMULUS_PATH, "r");
                if (fd == 0) begin
                        error_count++;
                        $display("could not open the stimulus file %s", STIMULUS_PATH);
                end else begin
                        line_no = 0;
                        while (!$feof(fd)) begin
                                line = "";
                                got = $fgets(line, fd);
                                line_no++;
                                if (got > 0 && is_data_line(line)) begin
                                        run_line(line, line_no);
                                end
                        end
                        $fclose(fd);
                end
                if (record_count == 0) begin
                        error_count++;
                        $display("no records were read from the stimulus file");
                end

                $display("summary: %0d records, %0d checks, %0d errors",
                         record_count, check_count, error_count);
                if (error_count == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

//--- hdl/cpu_trace_checker.sv
`timescale 1ns/1ps

module cpu_trace_checker
        import trace_syntax_pkg::*;
        import trace_record_pkg::*;
(
        input logic clk,
        input logic reset,
        input char_t char,
        input freq_t freq,
        output format_e format_type,
        output error_code_t error_code
);

        char_class_t char_class;
        field_cmd_t field_cmd;
        record_end_t record_end;
        record_fields_t fields;

        char_classifier classifier_i (
                .char(char),
                .char_class(char_class)
        );

        record_parser parser_i (
                .clk(clk),
                .reset(reset),
                .char_class(char_class),
                .field_cmd(field_cmd),
                .record_end(record_end)
        );

        field_accumulator accumulator_i (
                .clk(clk),
                .reset(reset),
                .char_class(char_class),
                .field_cmd(field_cmd),
                .fields(fields)
        );

        record_checker checker_i (
                .clk(clk),
                .reset(reset),
                .freq(freq),
                .fields(fields),
                .record_end(record_end),
                .format_type(format_type),
                .error_code(error_code)
        );

endmodule

//--- hdl/record_checker.sv
`timescale 1ns/1ps
`include "cpu_checker_config.svh"

module record_checker
        import trace_record_pkg::*;
(
        input logic clk,
        input logic reset,
        input freq_t freq,
        input record_fields_t fields,
        input record_end_t record_end,
        output format_e format_type,
        output error_code_t error_code
);

        time_t time_mask;
        logic time_bad;
        logic pc_bad;
        logic addr_bad;
        logic grf_bad;

        // freq = 2^k keeps k-1 low bits, anything else keeps the full mask.
        always_comb begin
                time_mask = time_t'((1 << `TIME_MASK_BITS_MAX) - 1);
                for (int k = 1; k <= `TIME_MASK_BITS_MAX; k++) begin
                        if (freq == freq_t'(1 << k)) begin
                                time_mask = time_t'((1 << (k - 1)) - 1);
                        end
                end
        end

        assign time_bad = |(fields.time_val & time_mask);
        assign pc_bad = (fields.pc < `PC_LOW) || (fields.pc > `PC_HIGH) || (|fields.pc[1:0]);
        assign addr_bad = (fields.addr < `ADDR_LOW) || (fields.addr > `ADDR_HIGH) ||
                          (|fields.addr[1:0]);
        assign grf_bad = (fields.grf > `GRF_MAX);

        always_ff @(posedge clk) begin
                if (reset) begin
                        format_type <= FMT_NONE;
                        error_code <= '0;
                end else if (record_end.done) begin
                        format_type <= record_end.form;
                        error_code.time_bad <= time_bad;
                        error_code.pc_bad <= pc_bad;
                        error_code.grf_bad <= grf_bad && (record_end.form == FMT_REG_WRITE);
                        error_code.addr_bad <= addr_bad && (record_end.form == FMT_MEM_WRITE);
                end else begin
                        format_type <= FMT_NONE; // report lasts one cycle.
                        error_code <= '0;
                end
        end

endmodule

//--- hdl/field_accumulator.sv
`timescale 1ns/1ps
`include "cpu_checker_config.svh"

module field_accumulator
        import trace_syntax_pkg::*;
        import trace_record_pkg::*;
(
        input logic clk,
        input logic reset,
        input char_class_t char_class,
        input field_cmd_t field_cmd,
        output record_fields_t fields
);

        time_t time_dec;
        grf_t grf_dec;
        word_t pc_hex;
        word_t addr_hex;

        // x*10 + d for the decimal fields.
        assign time_dec = time_t'((fields.time_val << 3) + (fields.time_val << 1) +
                                  char_class.value);
        assign grf_dec = grf_t'((fields.grf << 3) + (fields.grf << 1) + char_class.value);

        assign pc_hex = {fields.pc[`WORD_W-5:0], char_class.value};
        assign addr_hex = {fields.addr[`WORD_W-5:0], char_class.value};

        always_ff @(posedge clk) begin
                if (reset) begin
                        fields <= '0;
                end else if (field_cmd.clear) begin
                        fields <= '0; // every caret starts a fresh record.
                end else if (field_cmd.shift) begin
                        case (field_cmd.sel)
                        FIELD_TIME: fields.time_val <= time_dec;
                        FIELD_PC: fields.pc <= pc_hex;
                        FIELD_GRF: fields.grf <= grf_dec;
                        FIELD_ADDR: fields.addr <= addr_hex;
                        default: ;
                        endcase
                end
        end

endmodule

//--- hdl/record_parser.sv
`timescale 1ns/1ps
`include "cpu_checker_config.svh"

module record_parser
        import trace_syntax_pkg::*;
        import trace_record_pkg::*;
(
        input logic clk,
        input logic reset,
        input char_class_t char_class,
        output field_cmd_t field_cmd,
        output record_end_t record_end
);

        localparam digit_cnt_t DEC_MAX = digit_cnt_t'(`DEC_DIGITS_MAX);
        localparam digit_cnt_t HEX_LAST = digit_cnt_t'(`HEX_DIGITS - 1);

        parse_phase_e phase;
        parse_phase_e phase_next;
        digit_cnt_t digit_cnt;
        digit_cnt_t cnt_next;
        digit_cnt_t cnt_inc;
        logic is_mem;
        logic is_mem_next;

        assign cnt_inc = digit_cnt_t'(digit_cnt + 1'b1);

        always_comb begin
                phase_next = PH_IDLE; // anything unexpected rejects.
                cnt_next = '0;
                is_mem_next = is_mem;
                field_cmd.clear = char_class.caret;
                field_cmd.shift = 1'b0;
                field_cmd.sel = FIELD_TIME;
                record_end.done = 1'b0;
                record_end.form = FMT_NONE;

                if (char_class.caret) begin
                        phase_next = PH_TIME; // restart from any phase.
                end else begin
                        case (phase)
                        PH_TIME: begin
                                if (char_class.dec_digit && digit_cnt < DEC_MAX) begin
                                        phase_next = PH_TIME;
                                        cnt_next = cnt_inc;
                                        field_cmd.shift = 1'b1;
                                        field_cmd.sel = FIELD_TIME;
                                end else if (char_class.at && digit_cnt != '0) begin
                                        phase_next = PH_PC;
                                end
                        end
                        PH_PC: begin
                                if (char_class.hex_digit) begin
                                        field_cmd.shift = 1'b1;
                                        field_cmd.sel = FIELD_PC;
                                        if (digit_cnt == HEX_LAST) begin
                                                phase_next = PH_COLON;
                                        end else begin
                                                phase_next = PH_PC;
                                                cnt_next = cnt_inc;
                                        end
                                end
                        end
                        PH_COLON: begin
                                if (char_class.colon) begin
                                        phase_next = PH_KIND;
                                end
                        end
                        PH_KIND: begin
                                if (char_class.space) begin
                                        phase_next = PH_KIND;
                                end else if (char_class.dollar) begin
                                        phase_next = PH_GRF;
                                        is_mem_next = 1'b0;
                                end else if (char_class.star) begin
                                        phase_next = PH_ADDR;
                                        is_mem_next = 1'b1;
                                end
                        end
                        PH_GRF: begin
                                if (char_class.dec_digit && digit_cnt < DEC_MAX) begin
                                        phase_next = PH_GRF;
                                        cnt_next = cnt_inc;
                                        field_cmd.shift = 1'b1;
                                        field_cmd.sel = FIELD_GRF;
                                end else if (char_class.space && digit_cnt != '0) begin
                                        phase_next = PH_PRE_ARROW;
                                end else if (char_class.lt && digit_cnt != '0) begin
                                        phase_next = PH_ARROW_EQ;
                                end
                        end
                        PH_ADDR: begin
                                if (char_class.hex_digit) begin
                                        field_cmd.shift = 1'b1;
                                        field_cmd.sel = FIELD_ADDR;
                                        if (digit_cnt == HEX_LAST) begin
                                                phase_next = PH_PRE_ARROW;
                                        end else begin
                                                phase_next = PH_ADDR;
                                                cnt_next = cnt_inc;
                                        end
                                end
                        end
                        PH_PRE_ARROW: begin
                                if (char_class.space) begin
                                        phase_next = PH_PRE_ARROW;
                                end else if (char_class.lt) begin
                                        phase_next = PH_ARROW_EQ;
                                end
                        end
                        PH_ARROW_EQ: begin
                                if (char_class.eq) begin
                                        phase_next = PH_PRE_DATA;
                                end
                        end
                        PH_PRE_DATA: begin
                                if (char_class.space) begin
                                        phase_next = PH_PRE_DATA;
                                end else if (char_class.hex_digit) begin
                                        phase_next = PH_DATA; // first data digit.
                                        cnt_next = digit_cnt_t'(1);
                                end
                        end
                        PH_DATA: begin
                                if (char_class.hex_digit) begin
                                        if (digit_cnt == HEX_LAST) begin
                                                phase_next = PH_END_MARK;
                                        end else begin
                                                phase_next = PH_DATA;
                                                cnt_next = cnt_inc;
                                        end
                                end
                        end
                        PH_END_MARK: begin
                                if (char_class.hash) begin
                                        record_end.done = 1'b1;
                                        record_end.form = is_mem ? FMT_MEM_WRITE : FMT_REG_WRITE;
                                end
                        end
                        default: ; // idle waits for a caret.
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        phase <= PH_IDLE;
                        digit_cnt <= '0;
                        is_mem <= 1'b0;
                end else begin
                        phase <= phase_next;
                        digit_cnt <= cnt_next;
                        is_mem <= is_mem_next;
                end
        end

endmodule

//--- hdl/char_classifier.sv
`timescale 1ns/1ps
`include "cpu_checker_config.svh"

module char_classifier
        import trace_syntax_pkg::*;
(
        input char_t char,
        output char_class_t char_class
);

        logic is_dec;
        logic is_alpha;

        assign is_dec = (char >= `CH_DIGIT_0) && (char <= `CH_DIGIT_9);
        assign is_alpha = (char >= `CH_HEX_A) && (char <= `CH_HEX_F); // lower case only.

        always_comb begin
                char_class.caret = (char == `CH_CARET);
                char_class.at = (char == `CH_AT);
                char_class.colon = (char == `CH_COLON);
                char_class.space = (char == `CH_SPACE);
                char_class.dollar = (char == `CH_DOLLAR);
                char_class.star = (char == `CH_STAR);
                char_class.lt = (char == `CH_LT);
                char_class.eq = (char == `CH_EQ);
                char_class.hash = (char == `CH_HASH);
                char_class.dec_digit = is_dec;
                char_class.hex_digit = is_dec || is_alpha;

                if (is_dec) begin
                        char_class.value = nibble_t'(char - `CH_DIGIT_0);
                end else if (is_alpha) begin
                        char_class.value = nibble_t'(char - `CH_HEX_A + 8'd10); // a-f map to 10-15.
                end else begin
                        char_class.value = '0;
                end
        end

endmodule

//--- hdl/trace_record_pkg.sv
`include "cpu_checker_config.svh"

package trace_record_pkg;

        typedef logic [`TIME_W-1:0] time_t;
        typedef logic [`WORD_W-1:0] word_t;
        typedef logic [`GRF_W-1:0] grf_t;
        typedef logic [`FREQ_W-1:0] freq_t;

        typedef struct packed {
                time_t time_val;
                word_t pc;
                grf_t grf;
                word_t addr;
        } record_fields_t;

        typedef enum logic [1:0] {
                FMT_NONE = 2'd0,
                FMT_REG_WRITE = 2'd1,
                FMT_MEM_WRITE = 2'd2
        } format_e;

        // bit 3 down to bit 0.
        typedef struct packed {
                logic grf_bad;
                logic addr_bad;
                logic pc_bad;
                logic time_bad;
        } error_code_t;

        typedef struct packed {
                logic done;
                format_e form;
        } record_end_t;

endpackage

//--- hdl/trace_syntax_pkg.sv
`include "cpu_checker_config.svh"

package trace_syntax_pkg;

        typedef logic [`CHAR_W-1:0] char_t;
        typedef logic [3:0] nibble_t;
        typedef logic [3:0] digit_cnt_t;

        // one flag per recognised character or range.
        typedef struct packed {
                logic caret;
                logic at;
                logic colon;
                logic space;
                logic dollar;
                logic star;
                logic lt;
                logic eq;
                logic hash;
                logic dec_digit;
                logic hex_digit; // set for 0-9 too.
                nibble_t value;
        } char_class_t;

        typedef enum logic [3:0] {
                PH_IDLE,
                PH_TIME,
                PH_PC,
                PH_COLON,
                PH_KIND,
                PH_GRF,
                PH_ADDR,
                PH_PRE_ARROW,
                PH_ARROW_EQ,
                PH_PRE_DATA,
                PH_DATA,
                PH_END_MARK
        } parse_phase_e;

        typedef enum logic [1:0] {
                FIELD_TIME,
                FIELD_PC,
                FIELD_GRF,
                FIELD_ADDR
        } field_sel_e;

        typedef struct packed {
                logic clear;
                logic shift;
                field_sel_e sel;
        } field_cmd_t;

endpackage

//--- include/cpu_checker_config.svh
`ifndef CPU_CHECKER_CONFIG_SVH
`define CPU_CHECKER_CONFIG_SVH

`define CHAR_W 8
`define FREQ_W 16
`define TIME_W 16
`define WORD_W 32
`define GRF_W 16

`define DEC_DIGITS_MAX 4 // time and register fields.
`define HEX_DIGITS 8 // pc, address and data fields.

`define PC_LOW 32'h0000_3000
`define PC_HIGH 32'h0000_4fff
`define ADDR_LOW 32'h0000_0000
`define ADDR_HIGH 32'h0000_2fff
`define GRF_MAX 31

`define TIME_MASK_BITS_MAX 13 // also the largest listed freq power.

`define CH_CARET 8'h5e
`define CH_AT 8'h40
`define CH_COLON 8'h3a
`define CH_SPACE 8'h20
`define CH_DOLLAR 8'h24
`define CH_STAR 8'h2a
`define CH_LT 8'h3c
`define CH_EQ 8'h3d
`define CH_HASH 8'h23
`define CH_DIGIT_0 8'h30
`define CH_DIGIT_9 8'h39
`define CH_HEX_A 8'h61
`define CH_HEX_F 8'h66

`endif
